//--- include/dma_defs.svh
/*
 * DMA target shared constants
 * Flit layout, header field positions, bus widths and NoC packet sizing
 */
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Flit and bus widths
`define DMA_FLIT_WIDTH       34
`define DMA_DATA_WIDTH       32
`define DMA_ADDR_WIDTH       32

// Flit type in the two top bits
`define DMA_FLIT_TYPE_MSB    33
`define DMA_FLIT_TYPE_LSB    32

// Header flit fields
`define DMA_DEST_MSB         31
`define DMA_DEST_LSB         27
`define DMA_CLASS_MSB        26
`define DMA_CLASS_LSB        24
`define DMA_PKT_ID_MSB       23
`define DMA_PKT_ID_LSB       20
`define DMA_SOURCE_MSB       19
`define DMA_SOURCE_LSB       15
`define DMA_PKT_TYPE_MSB     14
`define DMA_PKT_TYPE_LSB     13
// Request last on the way in, response last on the way out
`define DMA_LAST_BIT         12
`define DMA_SIZE_MSB         7
`define DMA_SIZE_LSB         0

// Header field widths
`define DMA_TILE_WIDTH       5
`define DMA_PKT_ID_WIDTH     4
`define DMA_SIZE_WIDTH       8

// Packet sizing, header and address flit take two slots
`define DMA_NOC_PACKET_SIZE  16
`define DMA_MAX_PAYLOAD      (`DMA_NOC_PACKET_SIZE - 2)
`define DMA_READ_FIFO_DEPTH  3

`endif

//--- source/dma_noc_pkg.sv
/*
 * NoC protocol types for the DMA target
 * Flit type, DMA packet type and packet class encodings
 */
package dma_noc_pkg;

  // Flit type field
  typedef enum logic [1:0] {
    FLIT_PAYLOAD = 2'b00,
    FLIT_HEADER  = 2'b01,
    FLIT_LAST    = 2'b10,
    FLIT_SINGLE  = 2'b11
  } flit_type_e;

  // DMA packet type in the header
  typedef enum logic [1:0] {
    PKT_L2R_REQ  = 2'b00,
    PKT_R2L_REQ  = 2'b01,
    PKT_L2R_RESP = 2'b10,
    PKT_R2L_RESP = 2'b11
  } pkt_type_e;

  // Traffic class carried by all DMA packets
  typedef enum logic [2:0] {
    PKT_CLASS_DMA = 3'b010
  } pkt_class_e;

endpackage

//--- source/dma_target_pkg.sv
/*
 * Internal types of the DMA target
 * Controller FSM states and the kind of flit being sent out
 */
package dma_target_pkg;

  // Request handling FSM
  typedef enum logic [3:0] {
    ST_IDLE, ST_L2R_GETADDR, ST_L2R_DATA, ST_L2R_SENDRESP,
    ST_R2L_GETLADDR, ST_R2L_GETRADDR, ST_R2L_GENHDR, ST_R2L_GENADDR,
    ST_R2L_DATA
  } ctrl_state_e;

  // Selects what the response encoder puts on the NoC
  typedef enum logic [2:0] {
    KIND_NONE, KIND_L2R_RESP, KIND_R2L_HDR, KIND_R2L_ADDR,
    KIND_R2L_DATA, KIND_R2L_LAST
  } out_kind_e;

endpackage

//--- source/dma_read_fifo.sv
/*
 * Read data FIFO of the DMA target
 * Shifting storage with a one-hot fill position, full is a register bit
 */
`include "dma_defs.svh"

module dma_read_fifo (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push_i,
  input  logic [`DMA_DATA_WIDTH-1:0] data_i,
  input  logic                       pop_i,
  output logic [`DMA_DATA_WIDTH-1:0] data_o,
  output logic                       empty_o,
  output logic                       full_o
);

  localparam int DEPTH = `DMA_READ_FIFO_DEPTH;

  logic [`DMA_DATA_WIDTH-1:0] mem [DEPTH];
  // One-hot write position, bit 0 empty, top bit full
  logic [DEPTH:0]             pos;

  assign data_o  = mem[0];
  assign empty_o = pos[0];
  assign full_o  = pos[DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= {{DEPTH{1'b0}}, 1'b1};
    end else if (push_i && !pop_i) begin
      pos <= pos << 1;
    end else if (pop_i && !push_i) begin
      pos <= pos >> 1;
    end
  end

  ////////////////////
  // Storage shifting
  ////////////////////
  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    always_ff @(posedge clk) begin
      if (pop_i) begin
        // New word lands one slot lower when popping
        if (push_i && pos[i+1]) begin
          mem[i] <= data_i;
        end else if (i < DEPTH - 1) begin
          mem[i] <= mem[(i < DEPTH - 1) ? i + 1 : i];
        end
      end else if (push_i && pos[i]) begin
        mem[i] <= data_i;
      end
    end
  end

endmodule

//--- source/dma_resp_encoder.sv
/*
 * Response flit encoder
 * Builds the outgoing flit from the selected kind, purely combinational
 */
`include "dma_defs.svh"

module dma_resp_encoder #(
  parameter logic [`DMA_TILE_WIDTH-1:0] TILE_ID = '0
) (
  input  dma_target_pkg::out_kind_e      kind_i,
  input  logic [`DMA_TILE_WIDTH-1:0]     src_tile_i,
  input  logic [`DMA_PKT_ID_WIDTH-1:0]   pkt_id_i,
  input  logic [`DMA_SIZE_WIDTH-1:0]     pkt_size_i,
  input  logic                           resp_last_i,
  input  logic [`DMA_ADDR_WIDTH-1:0]     remote_adr_i,
  input  logic [`DMA_DATA_WIDTH-1:0]     fifo_data_i,
  output logic [`DMA_FLIT_WIDTH-1:0]     flit_o
);

  import dma_noc_pkg::*;
  import dma_target_pkg::*;

  always_comb begin
    flit_o = '0;
    case (kind_i)
      KIND_L2R_RESP: begin
        // Single flit back to the requester
        flit_o[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] = FLIT_SINGLE;
        flit_o[`DMA_DEST_MSB:`DMA_DEST_LSB]           = src_tile_i;
        flit_o[`DMA_CLASS_MSB:`DMA_CLASS_LSB]         = PKT_CLASS_DMA;
        flit_o[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB]       = pkt_id_i;
        flit_o[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB]   = PKT_L2R_RESP;
      end
      KIND_R2L_HDR: begin
        flit_o[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] = FLIT_HEADER;
        flit_o[`DMA_DEST_MSB:`DMA_DEST_LSB]           = src_tile_i;
        flit_o[`DMA_CLASS_MSB:`DMA_CLASS_LSB]         = PKT_CLASS_DMA;
        flit_o[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB]       = pkt_id_i;
        flit_o[`DMA_SOURCE_MSB:`DMA_SOURCE_LSB]       = TILE_ID;
        flit_o[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB]   = PKT_R2L_RESP;
        flit_o[`DMA_LAST_BIT]                         = resp_last_i;
        // Size counts words of this packet only
        flit_o[`DMA_SIZE_MSB:`DMA_SIZE_LSB]           = pkt_size_i;
      end
      KIND_R2L_ADDR: flit_o = {FLIT_PAYLOAD, remote_adr_i};
      KIND_R2L_DATA: flit_o = {FLIT_PAYLOAD, fifo_data_i};
      KIND_R2L_LAST: flit_o = {FLIT_LAST, fifo_data_i};
      default:       flit_o = '0;
    endcase
  end

endmodule

//--- source/dma_target_ctrl.sv
/*
 * DMA target controller
 * Decodes NoC requests, runs Wishbone writes and reads, and splits
 * read responses into NoC packets of bounded size
 */
`include "dma_defs.svh"

module dma_target_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [`DMA_FLIT_WIDTH-1:0]     noc_in_flit_i,
  input  logic                           noc_in_valid_i,
  output logic                           noc_in_ready_o,
  output logic                           noc_out_valid_o,
  input  logic                           noc_out_ready_i,
  output logic                           wb_cyc_o,
  output logic                           wb_stb_o,
  output logic                           wb_we_o,
  output logic [`DMA_ADDR_WIDTH-1:0]     wb_adr_o,
  input  logic                           wb_ack_i,
  output logic                           fifo_push_o,
  output logic                           fifo_pop_o,
  input  logic                           fifo_empty_i,
  input  logic                           fifo_full_i,
  output dma_target_pkg::out_kind_e      out_kind_o,
  output logic [`DMA_TILE_WIDTH-1:0]     src_tile_o,
  output logic [`DMA_PKT_ID_WIDTH-1:0]   pkt_id_o,
  output logic [`DMA_SIZE_WIDTH-1:0]     pkt_size_o,
  output logic                           resp_last_o,
  output logic [`DMA_ADDR_WIDTH-1:0]     remote_adr_o
);

  import dma_noc_pkg::*;
  import dma_target_pkg::*;

  localparam logic [`DMA_SIZE_WIDTH-1:0] MAX_WORDS = `DMA_MAX_PAYLOAD;

  ctrl_state_e                 state, state_nxt;
  flit_type_e                  in_type;
  pkt_type_e                   in_pkt_type;
  logic                        in_last, in_hs, hdr_accept, wb_done;
  logic                        rd_phase, rd_wait, req_last, pkt_end;
  logic [`DMA_ADDR_WIDTH-1:0]  local_adr, remote_base;
  // Word counts of the request total, closed packets and bus reads
  logic [`DMA_SIZE_WIDTH-1:0]  total_words, sent_words, rd_words;
  logic [`DMA_SIZE_WIDTH-1:0]  remaining, pkt_cnt;
  logic [`DMA_TILE_WIDTH-1:0]   src_tile_q;
  logic [`DMA_PKT_ID_WIDTH-1:0] pkt_id_q;

  // Input flit decode
  assign in_type     = flit_type_e'(noc_in_flit_i[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB]);
  assign in_pkt_type = pkt_type_e'(noc_in_flit_i[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB]);
  assign in_last     = (in_type == FLIT_LAST) || (in_type == FLIT_SINGLE);
  assign in_hs       = noc_in_valid_i && noc_in_ready_o;
  // Any header in idle is taken
  // Only known types start a request
  assign hdr_accept  = (state == ST_IDLE) && noc_in_valid_i && (in_type == FLIT_HEADER);
  assign wb_done     = wb_stb_o && wb_ack_i;

  // At most MAX_WORDS words per response packet
  assign remaining    = total_words - sent_words;
  assign pkt_size_o   = (remaining > MAX_WORDS) ? MAX_WORDS : remaining;
  assign resp_last_o  = (remaining <= MAX_WORDS);
  assign pkt_end      = (pkt_cnt == pkt_size_o - 1'b1);
  assign remote_adr_o = remote_base + {sent_words, 2'b00};

  assign src_tile_o = src_tile_q;
  assign pkt_id_o   = pkt_id_q;
  assign wb_adr_o   = local_adr;

  // Bus reads run in every R2L output state
  assign rd_phase = (state == ST_R2L_GENHDR) || (state == ST_R2L_GENADDR) ||
                    (state == ST_R2L_DATA);

  ////////////////////
  // Next state and outputs
  ////////////////////
  always_comb begin
    state_nxt       = state;
    noc_in_ready_o  = 1'b0;
    noc_out_valid_o = 1'b0;
    out_kind_o      = KIND_NONE;
    wb_cyc_o        = 1'b0;
    wb_stb_o        = 1'b0;
    wb_we_o         = 1'b0;
    fifo_pop_o      = 1'b0;
    case (state)
      ST_IDLE: begin
        noc_in_ready_o = 1'b1;
        if (hdr_accept) begin
          if (in_pkt_type == PKT_L2R_REQ) begin
            state_nxt = ST_L2R_GETADDR;
          end else if (in_pkt_type == PKT_R2L_REQ) begin
            state_nxt = ST_R2L_GETLADDR;
          end
        end
      end
      ST_L2R_GETADDR: begin
        noc_in_ready_o = 1'b1;
        if (noc_in_valid_i) begin
          state_nxt = ST_L2R_DATA;
        end
      end
      ST_L2R_DATA: begin
        // Payload flit stays on the input until the write is acked
        wb_cyc_o       = noc_in_valid_i;
        wb_stb_o       = noc_in_valid_i;
        wb_we_o        = 1'b1;
        noc_in_ready_o = noc_in_valid_i && wb_ack_i;
        if (in_hs && in_last) begin
          state_nxt = req_last ? ST_L2R_SENDRESP : ST_IDLE;
        end
      end
      ST_L2R_SENDRESP: begin
        noc_out_valid_o = 1'b1;
        out_kind_o      = KIND_L2R_RESP;
        if (noc_out_ready_i) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_R2L_GETLADDR: begin
        noc_in_ready_o = 1'b1;
        if (noc_in_valid_i) begin
          state_nxt = ST_R2L_GETRADDR;
        end
      end
      ST_R2L_GETRADDR: begin
        noc_in_ready_o = 1'b1;
        if (noc_in_valid_i) begin
          state_nxt = ST_R2L_GENHDR;
        end
      end
      ST_R2L_GENHDR: begin
        noc_out_valid_o = 1'b1;
        out_kind_o      = KIND_R2L_HDR;
        if (noc_out_ready_i) begin
          state_nxt = ST_R2L_GENADDR;
        end
      end
      ST_R2L_GENADDR: begin
        noc_out_valid_o = 1'b1;
        out_kind_o      = KIND_R2L_ADDR;
        if (noc_out_ready_i) begin
          state_nxt = ST_R2L_DATA;
        end
      end
      ST_R2L_DATA: begin
        noc_out_valid_o = !fifo_empty_i;
        out_kind_o      = pkt_end ? KIND_R2L_LAST : KIND_R2L_DATA;
        fifo_pop_o      = !fifo_empty_i && noc_out_ready_i;
        if (fifo_pop_o && pkt_end) begin
          state_nxt = resp_last_o ? ST_IDLE : ST_R2L_GENHDR;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase

    // Read strobe pauses after each ack and while the FIFO is full
    if (rd_phase && !rd_wait && !fifo_full_i && (rd_words != total_words)) begin
      wb_cyc_o = 1'b1;
      wb_stb_o = 1'b1;
    end
  end

  assign fifo_push_o = rd_phase && wb_done;

  ////////////////////
  // Control registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      rd_wait    <= 1'b0;
      sent_words <= '0;
      rd_words   <= '0;
      pkt_cnt    <= '0;
    end else begin
      state   <= state_nxt;
      rd_wait <= fifo_push_o;
      if (hdr_accept) begin
        sent_words <= '0;
        rd_words   <= '0;
        pkt_cnt    <= '0;
      end else begin
        if (fifo_push_o) begin
          rd_words <= rd_words + 1'b1;
        end
        if (fifo_pop_o && pkt_end) begin
          pkt_cnt    <= '0;
          sent_words <= sent_words + pkt_size_o;
        end else if (fifo_pop_o) begin
          pkt_cnt <= pkt_cnt + 1'b1;
        end
      end
    end
  end

  // Request fields and addresses
  always_ff @(posedge clk) begin
    if (hdr_accept) begin
      src_tile_q  <= noc_in_flit_i[`DMA_SOURCE_MSB:`DMA_SOURCE_LSB];
      pkt_id_q    <= noc_in_flit_i[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB];
      total_words <= noc_in_flit_i[`DMA_SIZE_MSB:`DMA_SIZE_LSB];
      req_last    <= noc_in_flit_i[`DMA_LAST_BIT];
    end
    if (in_hs && (state == ST_L2R_GETADDR || state == ST_R2L_GETLADDR)) begin
      local_adr <= noc_in_flit_i[`DMA_ADDR_WIDTH-1:0];
    end else if (wb_done) begin
      // Word addressing in bytes
      local_adr <= local_adr + 32'd4;
    end
    if (in_hs && state == ST_R2L_GETRADDR) begin
      remote_base <= noc_in_flit_i[`DMA_ADDR_WIDTH-1:0];
    end
  end

endmodule

//--- source/dma_wb_target.sv
/*
 * DMA target top level
 * NoC request packets in, Wishbone master out, responses back on the NoC
 */
`include "dma_defs.svh"

module dma_wb_target #(
  parameter logic [`DMA_TILE_WIDTH-1:0] TILE_ID = '0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`DMA_FLIT_WIDTH-1:0]  noc_in_flit_i,
  input  logic                        noc_in_valid_i,
  output logic                        noc_in_ready_o,
  output logic [`DMA_FLIT_WIDTH-1:0]  noc_out_flit_o,
  output logic                        noc_out_valid_o,
  input  logic                        noc_out_ready_i,
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [`DMA_ADDR_WIDTH-1:0]  wb_adr_o,
  output logic [`DMA_DATA_WIDTH-1:0]  wb_dat_o,
  input  logic [`DMA_DATA_WIDTH-1:0]  wb_dat_i,
  input  logic                        wb_ack_i
);

  import dma_target_pkg::*;

  out_kind_e                    out_kind;
  logic [`DMA_TILE_WIDTH-1:0]   src_tile;
  logic [`DMA_PKT_ID_WIDTH-1:0] pkt_id;
  logic [`DMA_SIZE_WIDTH-1:0]   pkt_size;
  logic                         resp_last;
  logic [`DMA_ADDR_WIDTH-1:0]   remote_adr;
  logic                         fifo_push, fifo_pop, fifo_empty, fifo_full;
  logic [`DMA_DATA_WIDTH-1:0]   fifo_data;

  // Write data is the payload flit content
  assign wb_dat_o = noc_in_flit_i[`DMA_DATA_WIDTH-1:0];

  dma_target_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .noc_in_flit_i   (noc_in_flit_i),
    .noc_in_valid_i  (noc_in_valid_i),
    .noc_in_ready_o  (noc_in_ready_o),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_ready_i (noc_out_ready_i),
    .wb_cyc_o        (wb_cyc_o),
    .wb_stb_o        (wb_stb_o),
    .wb_we_o         (wb_we_o),
    .wb_adr_o        (wb_adr_o),
    .wb_ack_i        (wb_ack_i),
    .fifo_push_o     (fifo_push),
    .fifo_pop_o      (fifo_pop),
    .fifo_empty_i    (fifo_empty),
    .fifo_full_i     (fifo_full),
    .out_kind_o      (out_kind),
    .src_tile_o      (src_tile),
    .pkt_id_o        (pkt_id),
    .pkt_size_o      (pkt_size),
    .resp_last_o     (resp_last),
    .remote_adr_o    (remote_adr)
  );

  dma_resp_encoder #(
    .TILE_ID (TILE_ID)
  ) u_enc (
    .kind_i       (out_kind),
    .src_tile_i   (src_tile),
    .pkt_id_i     (pkt_id),
    .pkt_size_i   (pkt_size),
    .resp_last_i  (resp_last),
    .remote_adr_i (remote_adr),
    .fifo_data_i  (fifo_data),
    .flit_o       (noc_out_flit_o)
  );

  // Read data straight from the bus into the FIFO
  dma_read_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .push_i  (fifo_push),
    .data_i  (wb_dat_i),
    .pop_i   (fifo_pop),
    .data_o  (fifo_data),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

endmodule

//--- verif/tb_wb_memory.sv
/*
 * Wishbone slave memory model
 * 256 words, acknowledge after a delay picked by the testbench
 */
`include "dma_defs.svh"

module tb_wb_memory (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`DMA_ADDR_WIDTH-1:0] wb_adr_i,
  input  logic [`DMA_DATA_WIDTH-1:0] wb_dat_i,
  output logic [`DMA_DATA_WIDTH-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  input  logic [1:0]                 delay_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORDS = 256;

  logic [`DMA_DATA_WIDTH-1:0] mem [WORDS];
  logic                       busy;
  logic [1:0]                 wait_cnt;
  logic [7:0]                 word_idx;

  // Every byte of the pattern depends on the word index
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'hD0, idx, ~idx, idx + 8'h3C};
  endfunction

  // Byte address to word index
  assign word_idx = wb_adr_i[9:2];
  assign wb_dat_o = mem[word_idx];
  assign wb_ack_o = wb_cyc_i && wb_stb_i && busy && (wait_cnt == 2'd0);

  // Wait counter loaded on the first strobe cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (wb_cyc_i && wb_stb_i) begin
      if (!busy) begin
        busy     <= 1'b1;
        wait_cnt <= delay_i;
      end else if (wb_ack_o) begin
        busy <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= fill_word(8'(i));
      end
    end else if (wb_ack_o && wb_we_i) begin
      mem[word_idx] <= wb_dat_i;
    end
  end

endmodule

//--- verif/dma_wb_target_sva.sv
/*
 * Protocol assertions for the DMA target
 * NoC output hold under back-pressure and Wishbone cycle rules
 */
`include "dma_defs.svh"

module dma_wb_target_sva (
  input logic                       clk,
  input logic                       rst,
  input logic [`DMA_FLIT_WIDTH-1:0] noc_out_flit_i,
  input logic                       noc_out_valid_i,
  input logic                       noc_out_ready_i,
  input logic                       wb_cyc_i,
  input logic                       wb_stb_i,
  input logic                       wb_ack_i,
  input logic [`DMA_ADDR_WIDTH-1:0] wb_adr_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Sticky flag, read by the testbench top
  logic assert_fail = 1'b0;

  // Offered flit stays put until taken
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid_i && !noc_out_ready_i |=> noc_out_valid_i && $stable(noc_out_flit_i))
    else begin
      assert_fail = 1'b1;
      $error("NoC output flit changed or dropped while stalled");
    end

  a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_stb_i |-> wb_cyc_i)
    else begin
      assert_fail = 1'b1;
      $error("Wishbone strobe high outside a bus cycle");
    end

  // Address held for the whole access
  a_adr_hold: assert property (@(posedge clk) disable iff (rst)
    wb_cyc_i && wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i))
    else begin
      assert_fail = 1'b1;
      $error("Wishbone address changed before acknowledge");
    end

endmodule

bind dma_wb_target dma_wb_target_sva u_sva (
  .clk             (clk),
  .rst             (rst),
  .noc_out_flit_i  (noc_out_flit_o),
  .noc_out_valid_i (noc_out_valid_o),
  .noc_out_ready_i (noc_out_ready_i),
  .wb_cyc_i        (wb_cyc_o),
  .wb_stb_i        (wb_stb_o),
  .wb_ack_i        (wb_ack_i),
  .wb_adr_i        (wb_adr_o)
);

//--- verif/tb_dma_wb_target.sv
/*
 * Testbench for the DMA target
 * Sends L2R and R2L requests, predicts response flits and the memory
 * image, and checks every NoC output handshake
 */
`include "dma_defs.svh"

module tb_dma_wb_target;
  timeunit 1ns;
  timeprecision 100ps;

  import dma_noc_pkg::*;

  localparam logic [`DMA_TILE_WIDTH-1:0] TILE_ID = 5'd3;
  // 5 + 3 + 4 + 9 + 30 request words
  localparam int          TOTAL_WORDS    = 51;
  localparam int          TIMEOUT_CYCLES = TOTAL_WORDS * 40 + 2000;
  localparam logic [31:0] SEED           = 32'd53;

  logic                       clk, rst;
  logic [`DMA_FLIT_WIDTH-1:0] noc_in_flit, noc_out_flit, exp_flit;
  logic                       noc_in_valid, noc_in_ready;
  logic                       noc_out_valid, noc_out_ready;
  logic                       wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`DMA_ADDR_WIDTH-1:0] wb_adr;
  logic [`DMA_DATA_WIDTH-1:0] wb_dat_w, wb_dat_r;
  logic [1:0]                 mem_delay;
  logic [31:0]                rnd_state;
  logic [31:0]                ref_mem [256];
  logic [31:0]                wr_data [64];
  logic [`DMA_FLIT_WIDTH-1:0] exp_q [$];
  int                         error_count;
  int                         cycles = 0;

  dma_wb_target #(.TILE_ID(TILE_ID)) dut0 (
    .clk             (clk),
    .rst             (rst),
    .noc_in_flit_i   (noc_in_flit),
    .noc_in_valid_i  (noc_in_valid),
    .noc_in_ready_o  (noc_in_ready),
    .noc_out_flit_o  (noc_out_flit),
    .noc_out_valid_o (noc_out_valid),
    .noc_out_ready_i (noc_out_ready),
    .wb_cyc_o        (wb_cyc),
    .wb_stb_o        (wb_stb),
    .wb_we_o         (wb_we),
    .wb_adr_o        (wb_adr),
    .wb_dat_o        (wb_dat_w),
    .wb_dat_i        (wb_dat_r),
    .wb_ack_i        (wb_ack)
  );

  tb_wb_memory u_mem (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .delay_i  (mem_delay)
  );

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Header layout shared by requests and responses
  function automatic logic [`DMA_FLIT_WIDTH-1:0] make_header(
      input flit_type_e ftype, input logic [4:0] dest, input logic [3:0] id,
      input logic [4:0] source, input pkt_type_e ptype, input logic last,
      input logic [7:0] size);
    logic [`DMA_FLIT_WIDTH-1:0] f;
    f = '0;
    f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] = ftype;
    f[`DMA_DEST_MSB:`DMA_DEST_LSB]           = dest;
    f[`DMA_CLASS_MSB:`DMA_CLASS_LSB]         = PKT_CLASS_DMA;
    f[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB]       = id;
    f[`DMA_SOURCE_MSB:`DMA_SOURCE_LSB]       = source;
    f[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB]   = ptype;
    f[`DMA_LAST_BIT]                         = last;
    f[`DMA_SIZE_MSB:`DMA_SIZE_LSB]           = size;
    return f;
  endfunction

  // Expected flits and memory image of one request packet
  function automatic void ref_model(input pkt_type_e ptype, input logic [4:0] src,
      input logic [3:0] id, input logic last, input logic [31:0] ladr,
      input logic [31:0] radr, input int n);
    int         base;
    int         sent;
    int         chunk;
    flit_type_e ft;
    base = int'(ladr[9:2]);
    sent = 0;
    if (ptype == PKT_L2R_REQ) begin
      for (int k = 0; k < n; k++) begin
        ref_mem[(base + k) % 256] = wr_data[k];
      end
      if (last) begin
        exp_q.push_back(make_header(FLIT_SINGLE, src, id, 5'd0, PKT_L2R_RESP, 1'b0, 8'd0));
      end
    end else begin
      // At most 14 words per packet and response-last on the final one
      while (sent < n) begin
        chunk = (n - sent > `DMA_MAX_PAYLOAD) ? `DMA_MAX_PAYLOAD : n - sent;
        exp_q.push_back(make_header(FLIT_HEADER, src, id, TILE_ID, PKT_R2L_RESP,
                                    (n - sent <= `DMA_MAX_PAYLOAD), 8'(chunk)));
        exp_q.push_back({FLIT_PAYLOAD, radr + 32'(sent * 4)});
        for (int k = 0; k < chunk; k++) begin
          ft = (k == chunk - 1) ? FLIT_LAST : FLIT_PAYLOAD;
          exp_q.push_back({ft, ref_mem[(base + sent + k) % 256]});
        end
        sent += chunk;
      end
    end
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Starts 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic send_flit(input logic [`DMA_FLIT_WIDTH-1:0] f);
    noc_in_flit  = f;
    noc_in_valid = 1'b1;
    @(posedge clk);
    while (!noc_in_ready) @(posedge clk);
    #1;
    noc_in_valid = 1'b0;
  endtask

  task automatic send_l2r(input logic [4:0] src, input logic [3:0] id, input logic last,
                          input logic [31:0] adr, input int n);
    flit_type_e ft;
    for (int k = 0; k < n; k++) begin
      wr_data[k] = {4'hE, id, adr[15:0], 8'(k)};
    end
    ref_model(PKT_L2R_REQ, src, id, last, adr, 32'd0, n);
    send_flit(make_header(FLIT_HEADER, TILE_ID, id, src, PKT_L2R_REQ, last, 8'(n)));
    send_flit({FLIT_PAYLOAD, adr});
    for (int k = 0; k < n; k++) begin
      ft = (k == n - 1) ? FLIT_LAST : FLIT_PAYLOAD;
      send_flit({ft, wr_data[k]});
    end
  endtask

  task automatic send_r2l(input logic [4:0] src, input logic [3:0] id,
                          input logic [31:0] ladr, input logic [31:0] radr, input int n);
    ref_model(PKT_R2L_REQ, src, id, 1'b1, ladr, radr, n);
    send_flit(make_header(FLIT_HEADER, TILE_ID, id, src, PKT_R2L_REQ, 1'b1, 8'(n)));
    send_flit({FLIT_PAYLOAD, ladr});
    send_flit({FLIT_LAST, radr});
  endtask

  // All expected flits seen and controller back in idle
  task automatic wait_idle();
    @(posedge clk);
    while (exp_q.size() != 0 || !noc_in_ready) @(posedge clk);
    #1;
  endtask

  task automatic check_memory();
    for (int i = 0; i < 256; i++) begin
      assert (u_mem.mem[i] === ref_mem[i])
        else report_error($sformatf("ERR mem[%0d] got 0x%h expected 0x%h",
                                    i, u_mem.mem[i], ref_mem[i]));
    end
  endtask

  ////////////////////
  // Clock, random and watchdog
  ////////////////////
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Back-pressure and ack delay from one xorshift stream
  always @(posedge clk) begin
    #1;
    rnd_state     = xorshift32(rnd_state);
    noc_out_ready = rnd_state[3];
    mem_delay     = rnd_state[9:8];
  end

  always @(posedge clk) begin
    cycles++;
    assert (cycles < TIMEOUT_CYCLES)
      else report_error($sformatf("Timeout, run did not finish in %0d cycles", cycles));
    assert (!dut0.u_sva.assert_fail)
      else report_error("A protocol assertion on the DUT ports failed");
  end

  // Output comparison on every accepted flit
  always @(posedge clk) begin
    if (!rst && noc_out_valid && noc_out_ready) begin
      assert (exp_q.size() != 0)
        else report_error($sformatf("Unexpected output flit 0x%h with nothing pending",
                                    noc_out_flit));
      exp_flit = exp_q.pop_front();
      assert (noc_out_flit === exp_flit)
        else report_error($sformatf("ERR noc_out_flit_o got 0x%h expected 0x%h",
                                    noc_out_flit, exp_flit));
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    rst           = 1'b1;
    noc_in_flit   = '0;
    noc_in_valid  = 1'b0;
    noc_out_ready = 1'b0;
    mem_delay     = 2'd0;
    rnd_state     = SEED;
    error_count   = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Idle outputs after reset
    assert (noc_out_valid === 1'b0)
      else report_error($sformatf("ERR noc_out_valid_o got 0x%h expected 0x0", noc_out_valid));
    assert (wb_cyc === 1'b0)
      else report_error($sformatf("ERR wb_cyc_o got 0x%h expected 0x0", wb_cyc));
    assert (noc_in_ready === 1'b1)
      else report_error($sformatf("ERR noc_in_ready_o got 0x%h expected 0x1", noc_in_ready));
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = u_mem.mem[i];
    end

    // Single packet write with response
    send_l2r(5'd9, 4'd2, 1'b1, 32'h0000_0040, 5);
    wait_idle();
    check_memory();

    // Write split over two packets with one response
    send_l2r(5'd12, 4'd7, 1'b0, 32'h0000_0080, 3);
    wait_idle();
    send_l2r(5'd12, 4'd7, 1'b1, 32'h0000_008C, 4);
    wait_idle();
    check_memory();

    // Short read, then a read split into three packets
    send_r2l(5'd17, 4'd4, 32'h0000_0040, 32'h1000_0100, 9);
    wait_idle();
    send_r2l(5'd21, 4'd11, 32'h0000_0200, 32'h2000_0400, 30);
    wait_idle();
    check_memory();

    if (error_count == 0 && !dut0.u_sva.assert_fail) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
source/dma_noc_pkg.sv
source/dma_target_pkg.sv
source/dma_read_fifo.sv
source/dma_resp_encoder.sv
source/dma_target_ctrl.sv
source/dma_wb_target.sv
verif/tb_wb_memory.sv
verif/dma_wb_target_sva.sv
verif/tb_dma_wb_target.sv

//--- Bender.yml
package:
  name: dma_wb_target

export_include_dirs:
  - include

sources:
  - source/dma_noc_pkg.sv
  - source/dma_target_pkg.sv
  - source/dma_read_fifo.sv
  - source/dma_resp_encoder.sv
  - source/dma_target_ctrl.sv
  - source/dma_wb_target.sv
  - target: test
    files:
      - verif/tb_wb_memory.sv
      - verif/dma_wb_target_sva.sv
      - verif/tb_dma_wb_target.sv
